// File: flist.f
r2b_pkg.sv
r2b_ctrl_if.sv
r2b_ram_if.sv
r2b_buf_if.sv
ram_1w1r.sv
r2b_ctrl_fsm.sv
r2b_addr_gen.sv
r2b_slice_buffer.sv
r2b_converter_v.sv
tb_r2b_converter_v.sv

// File: r2b_addr_gen.sv
/*
 * Row-to-block address generator
 * Counts rows in, sequences slice reads from the RAM and issues chunks
 */
`timescale 1ns/1ps

module r2b_addr_gen
    import r2b_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 en,
    input  logic                 in_valid,
    input  logic [ROW_WIDTH-1:0] in_data,
    r2b_ctrl_if.gen              ctrl,
    r2b_ram_if.gen               ram,
    r2b_buf_if.gen               bufc
);

    logic [ADDR_WIDTH-1:0]      wr_cnt;
    logic                       rows_all;
    logic [LOAD_IDX_WIDTH-1:0]  ld_cnt;
    logic                       ld_all;
    logic [CHUNK_IDX_WIDTH-1:0] ck_cnt;
    logic                       ck_all;
    logic [SLICE_IDX_WIDTH-1:0] slice_cnt;
    logic [ADDR_WIDTH-1:0]      slice_base;

    logic fill_take;
    logic load_take;
    logic load_exit;
    logic chunk_take;
    logic slice_step;

    assign fill_take  = en && (ctrl.state == ST_FILL) && in_valid && !rows_all;
    assign load_take  = en && (ctrl.state == ST_SLICE_RD) && !ld_all;
    assign load_exit  = en && (ctrl.state == ST_SLICE_RD) && ctrl.slice_loaded;
    assign chunk_take = en && (ctrl.state == ST_OUTPUT) && !ck_all;
    assign slice_step = en && (ctrl.state == ST_OUTPUT) && ctrl.chunks_done;

    // Done flags wait for the last write or load pulse to clear
    assign ctrl.fill_done       = rows_all && !ram.we;
    assign ctrl.slice_loaded    = ld_all && !bufc.load_en;
    assign ctrl.chunks_done     = ck_all && !bufc.chunk_en;
    assign ctrl.all_slices_done = (slice_cnt == SLICE_IDX_WIDTH'(NUM_SLICES - 1));

    assign ram.read_addr = slice_base + ADDR_WIDTH'(ld_cnt);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ram.we        <= 1'b0;
            bufc.load_en  <= 1'b0;
            bufc.chunk_en <= 1'b0;
            wr_cnt        <= '0;
            rows_all      <= 1'b0;
            ld_cnt        <= '0;
            ld_all        <= 1'b0;
            ck_cnt        <= '0;
            ck_all        <= 1'b0;
            slice_cnt     <= '0;
            slice_base    <= '0;
        end else begin
            // RAM side strobes are single pulses since the RAM never stalls
            ram.we       <= fill_take;
            bufc.load_en <= load_take;
            // Chunk strobe holds through a stall so the buffer takes it once
            if (en) begin
                bufc.chunk_en <= chunk_take;
            end

            if (fill_take) begin
                wr_cnt <= wr_cnt + 1'b1;
                if (wr_cnt == ADDR_WIDTH'(ROW - 1)) begin
                    rows_all <= 1'b1;
                end
            end

            if (load_take) begin
                if (ld_cnt == LOAD_IDX_WIDTH'(SLICE_ROWS - 1)) begin
                    ld_cnt <= '0;
                    ld_all <= 1'b1;
                end else begin
                    ld_cnt <= ld_cnt + 1'b1;
                end
            end else if (load_exit) begin
                ld_all <= 1'b0;
            end

            if (chunk_take) begin
                if (ck_cnt == CHUNK_IDX_WIDTH'(CHUNKS_PER_ROW - 1)) begin
                    ck_cnt <= '0;
                    ck_all <= 1'b1;
                end else begin
                    ck_cnt <= ck_cnt + 1'b1;
                end
            end else if (slice_step) begin
                ck_all     <= 1'b0;
                slice_cnt  <= slice_cnt + 1'b1;
                slice_base <= slice_base + ADDR_WIDTH'(SLICE_ROWS);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_take) begin
            ram.write_addr <= wr_cnt;
            ram.write_data <= in_data;
        end
        // Lines up with read_data one cycle after the address
        if (load_take) begin
            bufc.load_idx <= ld_cnt;
        end
        if (chunk_take) begin
            bufc.chunk_idx   <= ck_cnt;
            bufc.chunk_last  <= (ck_cnt == CHUNK_IDX_WIDTH'(CHUNKS_PER_ROW - 1));
            bufc.slice_final <= ctrl.all_slices_done;
        end
    end

endmodule

// File: r2b_buf_if.sv
/*
 * Slice buffer control strobes
 * Row load and chunk issue commands with their indices
 */
`timescale 1ns/1ps

interface r2b_buf_if import r2b_pkg::*; ();

    logic                       load_en;
    logic [LOAD_IDX_WIDTH-1:0]  load_idx;
    logic                       chunk_en;
    logic [CHUNK_IDX_WIDTH-1:0] chunk_idx;
    logic                       chunk_last;
    logic                       slice_final;

    modport gen (output load_en, load_idx, chunk_en, chunk_idx, chunk_last, slice_final);

    modport sbuf (input load_en, load_idx, chunk_en, chunk_idx, chunk_last, slice_final);

endinterface

// File: r2b_converter_v.sv
/*
 * Vertical row-to-block converter
 * Buffers a full matrix by rows and replays it as column blocks per slice
 */
`timescale 1ns/1ps

module r2b_converter_v
    import r2b_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 en,
    input  logic                 in_valid,
    input  logic [ROW_WIDTH-1:0] in_data,
    output logic                 slice_done,
    output logic                 output_ready,
    output logic                 slice_last,
    output logic                 buffer_done,
    output logic [OUT_WIDTH-1:0] out_data
);

    r2b_ctrl_if ctrl ();
    r2b_ram_if  ram ();
    r2b_buf_if  bufc ();

    r2b_ctrl_fsm u_fsm (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .ctrl  (ctrl.fsm)
    );

    r2b_addr_gen u_addr_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .en       (en),
        .in_valid (in_valid),
        .in_data  (in_data),
        .ctrl     (ctrl.gen),
        .ram      (ram.gen),
        .bufc     (bufc.gen)
    );

    ram_1w1r u_ram (
        .clk (clk),
        .mem (ram.mem)
    );

    r2b_slice_buffer u_slice_buf (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .ram          (ram.rd),
        .bufc         (bufc.sbuf),
        .out_data     (out_data),
        .output_ready (output_ready),
        .slice_done   (slice_done),
        .slice_last   (slice_last)
    );

    // Also raised with the final word, before the FSM reaches done
    assign buffer_done = (ctrl.state == ST_DONE) || slice_last;

endmodule

// File: r2b_ctrl_fsm.sv
/*
 * Row-to-block controller FSM
 * Sequences fill, slice read and output phases, frozen while en is low
 */
`timescale 1ns/1ps

module r2b_ctrl_fsm
    import r2b_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     en,
    r2b_ctrl_if.fsm  ctrl
);

    r2b_state_e state_q;
    r2b_state_e state_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else if (en) begin
            state_q <= state_next;
        end
    end

    always_comb begin
        state_next = state_q;
        case (state_q)
            ST_IDLE: begin
                state_next = ST_FILL;
            end
            ST_FILL: begin
                if (ctrl.fill_done) begin
                    state_next = ST_SLICE_RD;
                end
            end
            ST_SLICE_RD: begin
                if (ctrl.slice_loaded) begin
                    state_next = ST_OUTPUT;
                end
            end
            ST_OUTPUT: begin
                // Last chunk out, either the next slice or the end
                if (ctrl.chunks_done) begin
                    state_next = ctrl.all_slices_done ? ST_DONE : ST_SLICE_RD;
                end
            end
            ST_DONE: begin
                state_next = ST_DONE;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    assign ctrl.state = state_q;

endmodule

// File: r2b_ctrl_if.sv
/*
 * Controller status bus
 * State from the FSM, progress flags from the address generator
 */
`timescale 1ns/1ps

interface r2b_ctrl_if import r2b_pkg::*; ();

    r2b_state_e state;
    logic       fill_done;
    logic       slice_loaded;
    logic       chunks_done;
    logic       all_slices_done;

    modport fsm (
        output state,
        input  fill_done, slice_loaded, chunks_done, all_slices_done
    );

    modport gen (
        input  state,
        output fill_done, slice_loaded, chunks_done, all_slices_done
    );

endinterface

// File: r2b_pkg.sv
/*
 * Row-to-block converter shared definitions
 * Matrix sizes, derived widths and the controller state type
 */
package r2b_pkg;

    localparam int ELEM_WIDTH  = 16;
    localparam int ROW         = 8;
    localparam int COL         = 8;
    localparam int BLOCK_SIZE  = 2;
    localparam int NUM_CORES_V = 2;

    // Slice geometry
    localparam int SLICE_ROWS     = BLOCK_SIZE * NUM_CORES_V;
    localparam int CHUNKS_PER_ROW = COL / BLOCK_SIZE;
    localparam int NUM_SLICES     = ROW / SLICE_ROWS;

    // Bus widths
    localparam int ROW_WIDTH   = ELEM_WIDTH * COL;
    localparam int CHUNK_WIDTH = ELEM_WIDTH * BLOCK_SIZE;
    localparam int OUT_WIDTH   = CHUNK_WIDTH * SLICE_ROWS;

    // Index widths
    localparam int ADDR_WIDTH      = $clog2(ROW);
    localparam int CHUNK_IDX_WIDTH = $clog2(CHUNKS_PER_ROW);
    localparam int LOAD_IDX_WIDTH  = $clog2(SLICE_ROWS);
    localparam int SLICE_IDX_WIDTH = $clog2(NUM_SLICES);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FILL,
        ST_SLICE_RD,
        ST_OUTPUT,
        ST_DONE
    } r2b_state_e;

endpackage

// File: r2b_ram_if.sv
/*
 * Buffer RAM ports
 * Write and read side driven by the address generator
 */
`timescale 1ns/1ps

interface r2b_ram_if import r2b_pkg::*; ();

    logic                  we;
    logic [ADDR_WIDTH-1:0] write_addr;
    logic [ROW_WIDTH-1:0]  write_data;
    logic [ADDR_WIDTH-1:0] read_addr;
    logic [ROW_WIDTH-1:0]  read_data;

    modport gen (output we, write_addr, write_data, read_addr);

    modport mem (
        input  we, write_addr, write_data, read_addr,
        output read_data
    );

    modport rd (input read_data);

endinterface

// File: r2b_slice_buffer.sv
/*
 * Row-to-block slice buffer
 * Holds the rows of one slice and packs a column pair from each into a word
 */
`timescale 1ns/1ps

module r2b_slice_buffer
    import r2b_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 en,
    r2b_ram_if.rd                ram,
    r2b_buf_if.sbuf              bufc,
    output logic [OUT_WIDTH-1:0] out_data,
    output logic                 output_ready,
    output logic                 slice_done,
    output logic                 slice_last
);

    logic [ROW_WIDTH-1:0] row_q [SLICE_ROWS];
    logic [OUT_WIDTH-1:0] chunk_word;

    always_ff @(posedge clk) begin
        if (bufc.load_en) begin
            row_q[bufc.load_idx] <= ram.read_data;
        end
    end

    // Slice row 0 lands in the top pair, column 0 is the top of each row
    always_comb begin
        for (int i = 0; i < SLICE_ROWS; i++) begin
            chunk_word[OUT_WIDTH - 1 - i * CHUNK_WIDTH -: CHUNK_WIDTH] =
                row_q[i][ROW_WIDTH - 1 - int'(bufc.chunk_idx) * CHUNK_WIDTH -: CHUNK_WIDTH];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            output_ready <= 1'b0;
            slice_done   <= 1'b0;
            slice_last   <= 1'b0;
        end else if (en) begin
            output_ready <= bufc.chunk_en;
            slice_done   <= bufc.chunk_en && bufc.chunk_last;
            slice_last   <= bufc.chunk_en && bufc.chunk_last && bufc.slice_final;
        end else begin
            // Stalled cycles carry no word
            output_ready <= 1'b0;
            slice_done   <= 1'b0;
            slice_last   <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (en && bufc.chunk_en) begin
            out_data <= chunk_word;
        end
    end

endmodule

// File: ram_1w1r.sv
/*
 * Matrix buffer RAM
 * One synchronous write port, one read port with a one cycle latency
 */
`timescale 1ns/1ps

module ram_1w1r
    import r2b_pkg::*;
(
    input  logic      clk,
    r2b_ram_if.mem    mem
);

    logic [ROW_WIDTH-1:0] store [ROW];

    always_ff @(posedge clk) begin
        if (mem.we) begin
            store[mem.write_addr] <= mem.write_data;
        end
    end

    // Read runs every cycle, the caller times its own capture
    always_ff @(posedge clk) begin
        mem.read_data <= store[mem.read_addr];
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the row-to-block converter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f flist.f \
    --top-module tb_r2b_converter_v -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -x "test passed" > /dev/null \
    && echo "simulation ok" \
    || { echo "simulation reported a failure"; exit 1; }

// File: tb_r2b_converter_v.sv
/*
 * Testbench for the vertical row-to-block converter
 * Streams a random 8x8 matrix in and checks every output word against a table
 */
`timescale 1ns/1ps

module tb_r2b_converter_v
    import r2b_pkg::*;
();

    localparam int NUM_WORDS      = NUM_SLICES * CHUNKS_PER_ROW;
    localparam int STALL_CYCLES   = 4;
    localparam int STALL_TOTAL    = 2 * STALL_CYCLES;
    localparam int TAIL_CYCLES    = 12;
    localparam int TIMEOUT_CYCLES =
        (ROW + NUM_SLICES * (SLICE_ROWS + CHUNKS_PER_ROW + 4) + STALL_TOTAL) * 4;

    logic                 clk;
    logic                 rst_n;
    logic                 en;
    logic                 in_valid;
    logic [ROW_WIDTH-1:0] in_data;
    logic                 slice_done;
    logic                 output_ready;
    logic                 slice_last;
    logic                 buffer_done;
    logic [OUT_WIDTH-1:0] out_data;

    logic [ELEM_WIDTH-1:0] mat [ROW][COL];
    logic [ROW_WIDTH-1:0]  row_word [ROW];
    logic [OUT_WIDTH-1:0]  exp_word [NUM_WORDS];
    logic                  exp_sdone [NUM_WORDS];
    logic                  exp_slast [NUM_WORDS];

    // Idle cycles after each row, and the word counts where en drops
    int row_gap [ROW] = '{0, 1, 2, 0, 3, 1, 0, 2};
    int stall_at [2] = '{2, 5};

    int word_cnt   = 0;
    int rows_sent  = 0;
    int word_errs  = 0;
    int flag_errs  = 0;
    int other_errs = 0;

    r2b_converter_v u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .slice_done   (slice_done),
        .output_ready (output_ready),
        .slice_last   (slice_last),
        .buffer_done  (buffer_done),
        .out_data     (out_data)
    );

    always #50 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic fill_matrix();
        logic [15:0]           lfsr;
        logic [ELEM_WIDTH-1:0] elem;
        lfsr = 16'd46291;
        for (int r = 0; r < ROW; r++) begin
            for (int c = 0; c < COL; c++) begin
                elem = '0;
                for (int b = 0; b < ELEM_WIDTH; b++) begin
                    lfsr = lfsr_next(lfsr);
                    elem = {elem[ELEM_WIDTH-2:0], lfsr[0]};
                end
                mat[r][c] = elem;
                // Column 0 at the top of the row
                row_word[r][ROW_WIDTH - 1 - c * ELEM_WIDTH -: ELEM_WIDTH] = elem;
            end
        end
    endtask

    // Slice row 0 first, lower column first within each pair
    task automatic build_expected();
        logic [OUT_WIDTH-1:0] w;
        int                   idx;
        for (int s = 0; s < NUM_SLICES; s++) begin
            for (int k = 0; k < CHUNKS_PER_ROW; k++) begin
                w = '0;
                for (int i = 0; i < SLICE_ROWS; i++) begin
                    for (int j = 0; j < BLOCK_SIZE; j++) begin
                        w = (w << ELEM_WIDTH) |
                            OUT_WIDTH'(mat[s * SLICE_ROWS + i][k * BLOCK_SIZE + j]);
                    end
                end
                idx = s * CHUNKS_PER_ROW + k;
                exp_word[idx]  = w;
                exp_sdone[idx] = (k == CHUNKS_PER_ROW - 1);
                exp_slast[idx] = (k == CHUNKS_PER_ROW - 1) && (s == NUM_SLICES - 1);
            end
        end
    endtask

    task automatic check_word(input string name, input logic [OUT_WIDTH-1:0] exp_val,
                              input logic [OUT_WIDTH-1:0] act_val);
        if (act_val !== exp_val) begin
            $display("ERR %s expected %h actual %h", name, exp_val, act_val);
            word_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            $display("ERR %s expected %b actual %b", name, exp_val, act_val);
            flag_errs++;
        end
    endtask

    // Output monitor sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (output_ready && rows_sent < ROW) begin
                $display("output_ready rose before all rows were sent");
                other_errs++;
            end
            if (word_cnt >= NUM_WORDS) begin
                check_flag("buffer_done after last word", 1'b1, buffer_done);
                if (output_ready) begin
                    $display("output_ready rose again after the last word");
                    other_errs++;
                end
            end else if (output_ready) begin
                check_word($sformatf("word %0d data", word_cnt), exp_word[word_cnt], out_data);
                check_flag($sformatf("word %0d slice_done", word_cnt),
                           exp_sdone[word_cnt], slice_done);
                check_flag($sformatf("word %0d slice_last", word_cnt),
                           exp_slast[word_cnt], slice_last);
                check_flag($sformatf("word %0d buffer_done", word_cnt),
                           exp_slast[word_cnt], buffer_done);
                word_cnt++;
            end else begin
                check_flag("idle slice_done", 1'b0, slice_done);
                check_flag("idle slice_last", 1'b0, slice_last);
                check_flag("idle buffer_done", 1'b0, buffer_done);
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles, %0d of %0d words seen",
                 TIMEOUT_CYCLES, word_cnt, NUM_WORDS);
        $display("test failed");
        $finish;
    end

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        en       = 1'b0;
        in_valid = 1'b0;
        in_data  = '0;
        fill_matrix();
        build_expected();

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        en    <= 1'b1;
        @(negedge clk);
        check_flag("reset output_ready", 1'b0, output_ready);
        check_flag("reset slice_done", 1'b0, slice_done);
        check_flag("reset slice_last", 1'b0, slice_last);
        check_flag("reset buffer_done", 1'b0, buffer_done);

        // FSM leaves idle one edge after reset
        repeat (2) @(posedge clk);
        for (int r = 0; r < ROW; r++) begin
            @(posedge clk);
            in_valid <= 1'b1;
            in_data  <= row_word[r];
            rows_sent++;
            for (int g = 0; g < row_gap[r]; g++) begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;

        for (int s = 0; s < 2; s++) begin
            while (word_cnt < stall_at[s]) @(posedge clk);
            en <= 1'b0;
            repeat (STALL_CYCLES) @(posedge clk);
            en <= 1'b1;
        end

        while (word_cnt < NUM_WORDS) @(posedge clk);
        for (int t = 0; t < TAIL_CYCLES; t++) begin
            @(posedge clk);
            in_valid <= ~in_valid;
            in_data  <= ~in_data;
        end
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);

        $display("errors: %0d word, %0d flag, %0d other", word_errs, flag_errs, other_errs);
        if (word_errs + flag_errs + other_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
